/* logic/m2c_defs.svh */
// Bus shape and tracking-depth macros for the memory-bus to CSR adapter, included by RTL files.
`ifndef M2C_DEFS_SVH
`define M2C_DEFS_SVH

// one CSR data unit.
`define M2C_UNIT_WIDTH 32

// memory-bus beat, two units.
`define M2C_DATA_WIDTH 64
`define M2C_UNIT_COUNT 2

`define M2C_ADDR_WIDTH 16
`define M2C_ID_WIDTH 4

// length in units, 1 to 8, also used for response counters.
`define M2C_LENGTH_WIDTH 4

// outstanding non-posted requests.
`define M2C_TRACK_DEPTH 2

`endif

/* logic/m2c_pkg.sv */
// Shared command, response and tracking types for the adapter; referenced by scoped names.
`default_nettype none

`include "m2c_defs.svh"

package m2c_pkg;

  // memory-bus and CSR commands.
  typedef enum logic [1:0] {
    CMD_READ     = 2'b00,
    CMD_WRITE    = 2'b01,
    CMD_WRITE_NP = 2'b10
  } command_e;

  typedef enum logic {
    RESP      = 1'b0,
    RESP_DATA = 1'b1
  } response_e;

  // one entry per non-posted request.
  typedef struct packed {
    response_e                sresp;
    logic [`M2C_ID_WIDTH-1:0] sid;
    logic                     start_unit;
    logic                     ignore;
  } resp_info_t;

endpackage

`default_nettype wire

/* logic/m2c_track_if.sv */
// Response-tracking bundle between the splitter, the tracker FIFOs and the merger.
`timescale 1ns/100ps
`default_nettype none

`include "m2c_defs.svh"

interface m2c_track_if;
  logic                         info_push;
  m2c_pkg::resp_info_t          info_data;
  logic                         info_full;
  logic                         info_empty;
  m2c_pkg::resp_info_t          info_head;
  logic                         count_push;
  logic [`M2C_LENGTH_WIDTH-1:0] count_data;
  logic                         count_empty;
  logic [`M2C_LENGTH_WIDTH-1:0] count_head;
  logic                         pop;

  modport producer (
    output info_push, info_data, count_push, count_data,
    input  info_full
  );

  modport store (
    input  info_push, info_data, count_push, count_data, pop,
    output info_head, count_head, info_empty, info_full, count_empty
  );

  modport consumer (
    output pop,
    input  info_head, count_head, info_empty, count_empty
  );
endinterface

`default_nettype wire

/* logic/m2c_fifo.sv */
// Small synchronous FIFO with empty and full flags; the head is valid while not empty.
`timescale 1ns/100ps
`default_nettype none

module m2c_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
)(
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  input  var logic             i_push,
  input  var logic [WIDTH-1:0] i_data,
  input  var logic             i_pop,
  output var logic [WIDTH-1:0] o_data,
  output var logic             o_empty,
  output var logic             o_full
);
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 push_en;
  logic                 pop_en;

  assign push_en = i_push && !o_full;
  assign pop_en  = i_pop && !o_empty;
  assign o_empty = count == '0;
  assign o_full  = count == (PTR_WIDTH + 1)'(DEPTH);
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + PTR_WIDTH'(1);
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + PTR_WIDTH'(1);
      end
      if (push_en && !pop_en) begin
        count <= count + (PTR_WIDTH + 1)'(1);
      end else if (pop_en && !push_en) begin
        count <= count - (PTR_WIDTH + 1)'(1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      mem[wr_ptr] <= i_data;
    end
  end
endmodule

`default_nettype wire

/* logic/m2c_response_tracker.sv */
// Holds response info and issued-command counts of outstanding non-posted requests.
`timescale 1ns/100ps
`default_nettype none

`include "m2c_defs.svh"

module m2c_response_tracker (
  input var logic       i_clk,
  input var logic       i_rst_n,
  m2c_track_if.store    track
);
  localparam int INFO_WIDTH = $bits(m2c_pkg::resp_info_t);

  logic [INFO_WIDTH-1:0] info_head;

  m2c_fifo #(
    .WIDTH (INFO_WIDTH       ),
    .DEPTH (`M2C_TRACK_DEPTH )
  ) u_info_fifo (
    .i_clk   (i_clk            ),
    .i_rst_n (i_rst_n          ),
    .i_push  (track.info_push  ),
    .i_data  (track.info_data  ),
    .i_pop   (track.pop        ),
    .o_data  (info_head        ),
    .o_empty (track.info_empty ),
    .o_full  (track.info_full  )
  );

  assign track.info_head = m2c_pkg::resp_info_t'(info_head);

  // never full on push, its entry trails the info entry.
  m2c_fifo #(
    .WIDTH (`M2C_LENGTH_WIDTH ),
    .DEPTH (`M2C_TRACK_DEPTH  )
  ) u_count_fifo (
    .i_clk   (i_clk             ),
    .i_rst_n (i_rst_n           ),
    .i_push  (track.count_push  ),
    .i_data  (track.count_data  ),
    .i_pop   (track.pop         ),
    .o_data  (track.count_head  ),
    .o_empty (track.count_empty ),
    .o_full  ()
  );
endmodule

`default_nettype wire

/* logic/m2c_request_splitter.sv */
// Splits memory-bus commands and write beats into one CSR command per 32-bit unit.
`timescale 1ns/100ps
`default_nettype none

`include "m2c_defs.svh"

module m2c_request_splitter (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_force_np_write,
  input  var logic                           i_mcmd_valid,
  output var logic                           o_scmd_accept,
  input  var m2c_pkg::command_e              i_mcmd,
  input  var logic [`M2C_ID_WIDTH-1:0]       i_mid,
  input  var logic [`M2C_ADDR_WIDTH-1:0]     i_maddr,
  input  var logic [`M2C_LENGTH_WIDTH-1:0]   i_mlength,
  input  var logic                           i_mdata_valid,
  output var logic                           o_sdata_accept,
  input  var logic [`M2C_DATA_WIDTH-1:0]     i_mdata,
  input  var logic [`M2C_DATA_WIDTH/8-1:0]   i_mdata_byteen,
  output var logic                           o_csr_mcmd_valid,
  input  var logic                           i_csr_scmd_accept,
  output var m2c_pkg::command_e              o_csr_mcmd,
  output var logic [`M2C_ADDR_WIDTH-1:0]     o_csr_maddr,
  output var logic [`M2C_UNIT_WIDTH-1:0]     o_csr_mdata,
  output var logic [`M2C_UNIT_WIDTH/8-1:0]   o_csr_mdata_byteen,
  m2c_track_if.producer                      track
);
  localparam int AW         = `M2C_ADDR_WIDTH;
  localparam int LW         = `M2C_LENGTH_WIDTH;
  localparam int UNIT_BYTES = `M2C_UNIT_WIDTH / 8;
  localparam int UNIT_LSB   = $clog2(UNIT_BYTES);
  localparam int IDX_W      = $clog2(`M2C_UNIT_COUNT);

  logic             busy;
  logic [LW-1:0]    remain_q;
  logic [IDX_W-1:0] unit_q;
  logic [AW-1:0]    addr_q;
  logic [LW-1:0]    issued_q;
  logic [LW-1:0]    remain;
  logic [IDX_W-1:0] unit;
  logic [AW-1:0]    addr;
  logic             last_unit;
  logic             is_write;
  logic             skip;
  logic             non_posted;
  logic             req_valid;
  logic             step;
  m2c_pkg::resp_info_t info;

  // first unit comes straight from the command.
  always_comb begin
    if (busy) begin
      remain = remain_q;
      unit   = unit_q;
      addr   = addr_q;
    end else begin
      remain = i_mlength;
      unit   = i_maddr[UNIT_LSB+:IDX_W];
      addr   = {i_maddr[AW-1:UNIT_LSB], UNIT_LSB'(0)};
    end
  end

  always_comb begin
    last_unit          = remain == LW'(1);
    is_write           = i_mcmd != m2c_pkg::CMD_READ;
    o_csr_mdata        = i_mdata[`M2C_UNIT_WIDTH*unit+:`M2C_UNIT_WIDTH];
    o_csr_mdata_byteen = i_mdata_byteen[UNIT_BYTES*unit+:UNIT_BYTES];
    o_csr_maddr        = addr;
    skip               = is_write && (o_csr_mdata_byteen == '0);
    if (i_force_np_write && (i_mcmd == m2c_pkg::CMD_WRITE)) begin
      o_csr_mcmd = m2c_pkg::CMD_WRITE_NP;
    end else begin
      o_csr_mcmd = i_mcmd;
    end
    non_posted = o_csr_mcmd != m2c_pkg::CMD_WRITE;

    // a new non-posted request needs a free info entry.
    req_valid = i_mcmd_valid && (!is_write || i_mdata_valid) &&
                (!non_posted || busy || !track.info_full);
    o_csr_mcmd_valid = req_valid && !skip;
    step             = req_valid && (skip || i_csr_scmd_accept);
    o_scmd_accept    = step && last_unit;
    o_sdata_accept   = step && is_write &&
                       (last_unit || (unit == IDX_W'(`M2C_UNIT_COUNT - 1)));
  end

  always_comb begin
    info.sresp      = is_write ? m2c_pkg::RESP : m2c_pkg::RESP_DATA;
    info.sid        = i_mid;
    info.start_unit = i_maddr[UNIT_LSB];
    info.ignore     = i_force_np_write && (i_mcmd == m2c_pkg::CMD_WRITE);
    track.info_data  = info;
    track.info_push  = step && non_posted && !busy;
    track.count_push = step && non_posted && last_unit;
    track.count_data = issued_q + LW'(!skip);
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      remain_q <= '0;
      unit_q   <= '0;
      addr_q   <= '0;
      issued_q <= '0;
    end else if (step) begin
      busy     <= !last_unit;
      remain_q <= remain - LW'(1);
      unit_q   <= unit + IDX_W'(1);
      addr_q   <= addr + AW'(UNIT_BYTES);
      issued_q <= last_unit ? '0 : track.count_data;
    end
  end
endmodule

`default_nettype wire

/* logic/m2c_response_merger.sv */
// Merges CSR responses into memory-bus responses, packing read units into 64-bit beats.
`timescale 1ns/100ps
`default_nettype none

`include "m2c_defs.svh"

module m2c_response_merger (
  input  var logic                         i_clk,
  input  var logic                         i_rst_n,
  input  var logic                         i_csr_sresp_valid,
  output var logic                         o_csr_mresp_accept,
  input  var logic [`M2C_UNIT_WIDTH-1:0]   i_csr_sdata,
  input  var logic                         i_csr_serror,
  output var logic                         o_sresp_valid,
  input  var logic                         i_mresp_accept,
  output var m2c_pkg::response_e           o_sresp,
  output var logic [`M2C_ID_WIDTH-1:0]     o_sid,
  output var logic [`M2C_DATA_WIDTH-1:0]   o_sdata,
  output var logic                         o_serror,
  output var logic                         o_sresp_last,
  m2c_track_if.consumer                    track
);
  localparam int LW    = `M2C_LENGTH_WIDTH;
  localparam int IDX_W = $clog2(`M2C_UNIT_COUNT);

  logic                       busy;
  logic [LW-1:0]              resp_cnt_q;
  logic [IDX_W-1:0]           unit_q;
  logic [`M2C_UNIT_WIDTH-1:0] data_q;
  logic                       error_q;
  logic [LW-1:0]              cnt_next;
  logic [IDX_W-1:0]           unit;
  logic                       last_resp;
  logic                       zero_write;
  logic                       send;
  logic                       resp_ack;
  m2c_pkg::resp_info_t        head;

  always_comb begin
    head     = track.info_head;
    cnt_next = (busy ? resp_cnt_q : '0) + LW'(1);
    unit     = busy ? unit_q : head.start_unit;

    // the count entry shows up once the request is fully issued.
    last_resp  = !track.count_empty && (track.count_head != '0) &&
                 (cnt_next == track.count_head);
    zero_write = !track.count_empty && (track.count_head == '0);
    if (head.sresp == m2c_pkg::RESP_DATA) begin
      send = last_resp || (unit == IDX_W'(`M2C_UNIT_COUNT - 1));
    end else begin
      send = last_resp;
    end
  end

  always_comb begin
    o_sresp_valid      = 1'b0;
    o_csr_mresp_accept = 1'b0;
    if (!track.info_empty) begin
      if (zero_write) begin
        o_sresp_valid = !head.ignore;
      end else if (head.ignore || !send) begin
        o_csr_mresp_accept = 1'b1;
      end else begin
        o_csr_mresp_accept = i_mresp_accept;
        o_sresp_valid      = i_csr_sresp_valid;
      end
    end
    resp_ack  = i_csr_sresp_valid && o_csr_mresp_accept;
    track.pop = (zero_write && (head.ignore || i_mresp_accept)) || (resp_ack && last_resp);
  end

  always_comb begin
    o_sresp      = head.sresp;
    o_sid        = head.sid;
    o_sresp_last = last_resp || zero_write;
    o_serror     = !zero_write && (error_q || i_csr_serror);
    o_sdata      = {i_csr_sdata, (unit == '0) ? i_csr_sdata : data_q};
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy       <= 1'b0;
      resp_cnt_q <= '0;
      unit_q     <= '0;
    end else begin
      if (track.pop) begin
        busy <= 1'b0;
      end else if (resp_ack) begin
        busy <= 1'b1;
      end
      if (resp_ack) begin
        resp_cnt_q <= cnt_next;
        unit_q     <= unit + IDX_W'(1);
      end
    end
  end

  // error collects over one beat, or over a whole write.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      error_q <= 1'b0;
    end else if (track.pop || (o_sresp_valid && i_mresp_accept)) begin
      error_q <= 1'b0;
    end else if (resp_ack) begin
      error_q <= error_q || i_csr_serror;
    end
  end

  always_ff @(posedge i_clk) begin
    if (resp_ack && (unit == '0)) begin
      data_q <= i_csr_sdata;
    end
  end
endmodule

`default_nettype wire

/* logic/membus2csrbus_adapter.sv */
// Top level of the memory-bus to CSR-bus adapter; instantiate with plain bus ports.
`timescale 1ns/100ps
`default_nettype none

`include "m2c_defs.svh"

module membus2csrbus_adapter (
  input  var logic                           i_clk,
  input  var logic                           i_rst_n,
  input  var logic                           i_force_np_write,
  input  var logic                           i_mcmd_valid,
  output var logic                           o_scmd_accept,
  input  var m2c_pkg::command_e              i_mcmd,
  input  var logic [`M2C_ID_WIDTH-1:0]       i_mid,
  input  var logic [`M2C_ADDR_WIDTH-1:0]     i_maddr,
  input  var logic [`M2C_LENGTH_WIDTH-1:0]   i_mlength,
  input  var logic                           i_mdata_valid,
  output var logic                           o_sdata_accept,
  input  var logic [`M2C_DATA_WIDTH-1:0]     i_mdata,
  input  var logic [`M2C_DATA_WIDTH/8-1:0]   i_mdata_byteen,
  output var logic                           o_sresp_valid,
  input  var logic                           i_mresp_accept,
  output var m2c_pkg::response_e             o_sresp,
  output var logic [`M2C_ID_WIDTH-1:0]       o_sid,
  output var logic [`M2C_DATA_WIDTH-1:0]     o_sdata,
  output var logic                           o_serror,
  output var logic                           o_sresp_last,
  output var logic                           o_csr_mcmd_valid,
  input  var logic                           i_csr_scmd_accept,
  output var m2c_pkg::command_e              o_csr_mcmd,
  output var logic [`M2C_ADDR_WIDTH-1:0]     o_csr_maddr,
  output var logic [`M2C_UNIT_WIDTH-1:0]     o_csr_mdata,
  output var logic [`M2C_UNIT_WIDTH/8-1:0]   o_csr_mdata_byteen,
  input  var logic                           i_csr_sresp_valid,
  output var logic                           o_csr_mresp_accept,
  input  var logic [`M2C_UNIT_WIDTH-1:0]     i_csr_sdata,
  input  var logic                           i_csr_serror
);
  m2c_track_if track ();

  m2c_request_splitter u_request_splitter (
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            ),
    .i_force_np_write   (i_force_np_write   ),
    .i_mcmd_valid       (i_mcmd_valid       ),
    .o_scmd_accept      (o_scmd_accept      ),
    .i_mcmd             (i_mcmd             ),
    .i_mid              (i_mid              ),
    .i_maddr            (i_maddr            ),
    .i_mlength          (i_mlength          ),
    .i_mdata_valid      (i_mdata_valid      ),
    .o_sdata_accept     (o_sdata_accept     ),
    .i_mdata            (i_mdata            ),
    .i_mdata_byteen     (i_mdata_byteen     ),
    .o_csr_mcmd_valid   (o_csr_mcmd_valid   ),
    .i_csr_scmd_accept  (i_csr_scmd_accept  ),
    .o_csr_mcmd         (o_csr_mcmd         ),
    .o_csr_maddr        (o_csr_maddr        ),
    .o_csr_mdata        (o_csr_mdata        ),
    .o_csr_mdata_byteen (o_csr_mdata_byteen ),
    .track              (track.producer     )
  );

  m2c_response_tracker u_response_tracker (
    .i_clk   (i_clk       ),
    .i_rst_n (i_rst_n     ),
    .track   (track.store )
  );

  m2c_response_merger u_response_merger (
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            ),
    .i_csr_sresp_valid  (i_csr_sresp_valid  ),
    .o_csr_mresp_accept (o_csr_mresp_accept ),
    .i_csr_sdata        (i_csr_sdata        ),
    .i_csr_serror       (i_csr_serror       ),
    .o_sresp_valid      (o_sresp_valid      ),
    .i_mresp_accept     (i_mresp_accept     ),
    .o_sresp            (o_sresp            ),
    .o_sid              (o_sid              ),
    .o_sdata            (o_sdata            ),
    .o_serror           (o_serror           ),
    .o_sresp_last       (o_sresp_last       ),
    .track              (track.consumer     )
  );
endmodule

`default_nettype wire

/* tb/tb_membus2csrbus_adapter.sv */
// Table-driven testbench for the memory-bus to CSR adapter; run as the simulation top.
`timescale 1ns/100ps
`default_nettype none

module tb_membus2csrbus_adapter;
  localparam int NUM_ROWS = 9;
  localparam int CYCLE_LIMIT = 64 * NUM_ROWS + 100;
  // accesses to this register answer with an error.
  localparam int ERR_REG = 0;

  typedef struct {
    string             name;
    m2c_pkg::command_e cmd;
    logic              force_np;
    logic [3:0]        id;
    logic [15:0]       addr;
    logic [3:0]        len;
    logic [3:0][63:0]  data;
    logic [3:0][7:0]   be;
    logic              resp;
  } row_t;

  typedef struct {
    m2c_pkg::command_e cmd;
    logic [15:0]       addr;
    logic [31:0]       data;
    logic [3:0]        be;
  } csr_cmd_t;

  typedef struct {
    m2c_pkg::response_e kind;
    logic [3:0]         id;
    logic [63:0]        data;
    logic [63:0]        mask;
    logic               err;
    logic               last;
  } mem_resp_t;

  logic i_clk = 1'b0;
  logic i_rst_n, i_force_np_write, i_mcmd_valid, i_mdata_valid, i_mresp_accept;
  logic i_csr_scmd_accept, i_csr_sresp_valid, i_csr_serror;
  m2c_pkg::command_e i_mcmd;
  logic [3:0]  i_mid, i_mlength;
  logic [15:0] i_maddr;
  logic [63:0] i_mdata;
  logic [7:0]  i_mdata_byteen;
  logic [31:0] i_csr_sdata;
  logic o_scmd_accept, o_sdata_accept, o_sresp_valid, o_serror, o_sresp_last;
  logic o_csr_mcmd_valid, o_csr_mresp_accept;
  m2c_pkg::response_e o_sresp;
  m2c_pkg::command_e  o_csr_mcmd;
  logic [3:0]  o_sid, o_csr_mdata_byteen;
  logic [63:0] o_sdata;
  logic [15:0] o_csr_maddr;
  logic [31:0] o_csr_mdata;

  row_t        rows [NUM_ROWS];
  csr_cmd_t    exp_csr [$];
  mem_resp_t   exp_resp [$];
  logic [32:0] pend [$];
  logic [31:0] regs [16];
  logic [31:0] shadow [16];
  logic [31:0] lfsr_state = 32'hf225_2fe8;
  logic [3:0][63:0] cur_data;
  logic [3:0][7:0]  cur_be;
  int          beat_idx;
  int          cycles;
  logic        req_done;
  string       cur_name;

  membus2csrbus_adapter u_membus2csrbus_adapter (.*);

  always #4 i_clk = ~i_clk;

  // galois step yielding one bit per call.
  function automatic logic take_bit();
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hd000_0001 : 32'h0);
    return lfsr_state[0];
  endfunction

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
    assert (exp === act) else begin
      $display("error %s %s expected %h actual %h", cur_name, what, exp, act);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(string msg);
    $display("%s in test %s", msg, cur_name);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic fill_rows();
    rows[0] = '{"posted_burst", m2c_pkg::CMD_WRITE, 1'b0, 4'h1, 16'h0000, 4'd4,
                {64'h0, 64'h0, 64'h4444_4444_3333_3333, 64'h2222_2222_1111_1111},
                {8'h00, 8'h00, 8'hff, 8'hff}, 1'b0};
    rows[1] = '{"read_odd_start", m2c_pkg::CMD_READ, 1'b0, 4'h2, 16'h0004, 4'd3,
                {64'h0, 64'h0, 64'h0, 64'h0}, {8'h00, 8'h00, 8'h00, 8'h00}, 1'b1};
    rows[2] = '{"skip_unit", m2c_pkg::CMD_WRITE, 1'b0, 4'h3, 16'h0010, 4'd4,
                {64'h0, 64'h0, 64'h6666_6666_5555_5555, 64'h8888_8888_7777_7777},
                {8'h00, 8'h00, 8'hf3, 8'h0f}, 1'b0};
    rows[3] = '{"np_write", m2c_pkg::CMD_WRITE_NP, 1'b0, 4'h4, 16'h0020, 4'd2,
                {64'h0, 64'h0, 64'h0, 64'habcd_0002_abcd_0001},
                {8'h00, 8'h00, 8'h00, 8'hff}, 1'b1};
    rows[4] = '{"forced_write", m2c_pkg::CMD_WRITE, 1'b1, 4'h5, 16'h0028, 4'd3,
                {64'h0, 64'h0, 64'h0000_0000_9999_0003, 64'h9999_0002_9999_0001},
                {8'h00, 8'h00, 8'h0f, 8'hff}, 1'b0};
    rows[5] = '{"np_all_skipped", m2c_pkg::CMD_WRITE_NP, 1'b0, 4'h6, 16'h0030, 4'd2,
                {64'h0, 64'h0, 64'h0, 64'hdead_dead_dead_dead},
                {8'h00, 8'h00, 8'h00, 8'h00}, 1'b1};
    rows[6] = '{"read_back", m2c_pkg::CMD_READ, 1'b0, 4'h7, 16'h0000, 4'd8,
                {64'h0, 64'h0, 64'h0, 64'h0}, {8'h00, 8'h00, 8'h00, 8'h00}, 1'b1};
    rows[7] = '{"read_single", m2c_pkg::CMD_READ, 1'b0, 4'h8, 16'h0024, 4'd1,
                {64'h0, 64'h0, 64'h0, 64'h0}, {8'h00, 8'h00, 8'h00, 8'h00}, 1'b1};
    rows[8] = '{"np_write_wrap", m2c_pkg::CMD_WRITE_NP, 1'b0, 4'h9, 16'h003c, 4'd3,
                {64'h0, 64'h0, 64'h5a5a_0003_5a5a_0002, 64'h5a5a_0001_0000_0000},
                {8'h00, 8'h00, 8'hff, 8'hf0}, 1'b1};
  endtask

  // derive expected CSR commands and responses of one row from the shadow registers.
  task automatic plan_row(row_t r);
    csr_cmd_t  c;
    mem_resp_t m;
    int        u;
    int        b;
    int        l;
    int        idx;
    logic [15:0] a;
    logic [3:0]  be4;
    logic [31:0] d;
    logic        werr;
    m = '{m2c_pkg::RESP_DATA, r.id, 64'h0, 64'h0, 1'b0, 1'b0};
    werr = 1'b0;
    for (int k = 0; k < int'(r.len); k++) begin
      u = int'(r.addr[2]) + k;
      b = u / 2;
      l = u % 2;
      a = (r.addr & 16'hfffc) + 16'(4 * k);
      idx = int'(a[5:2]);
      be4 = r.be[b][4*l+:4];
      d = r.data[b][32*l+:32];
      if (r.cmd == m2c_pkg::CMD_READ) begin
        exp_csr.push_back('{m2c_pkg::CMD_READ, a, 32'h0, 4'h0});
        m.data[32*l+:32] = shadow[idx];
        m.mask[32*l+:32] = 32'hffff_ffff;
        m.err = m.err | (idx == ERR_REG);
        if (l == 1 || k == int'(r.len) - 1) begin
          m.last = (k == int'(r.len) - 1);
          exp_resp.push_back(m);
          m.data = 64'h0;
          m.mask = 64'h0;
          m.err = 1'b0;
        end
      end else if (be4 != 4'h0) begin
        c.cmd = (r.force_np || r.cmd == m2c_pkg::CMD_WRITE_NP) ?
                m2c_pkg::CMD_WRITE_NP : m2c_pkg::CMD_WRITE;
        c.addr = a;
        c.data = d;
        c.be = be4;
        exp_csr.push_back(c);
        werr = werr | (idx == ERR_REG);
        for (int j = 0; j < 4; j++) begin
          if (be4[j]) shadow[idx][8*j+:8] = d[8*j+:8];
        end
      end
    end
    if (r.cmd != m2c_pkg::CMD_READ && r.resp) begin
      exp_resp.push_back('{m2c_pkg::RESP, r.id, 64'h0, 64'h0, werr, 1'b1});
    end
  endtask

  // CSR register model, response monitor and stall generator.
  initial begin
    logic cmd_fire, data_fire, csr_fire, resp_fire, mresp_fire;
    csr_cmd_t  c;
    mem_resp_t m;
    wait (i_rst_n);
    forever begin
      @(negedge i_clk);
      cmd_fire   = i_mcmd_valid && o_scmd_accept;
      data_fire  = i_mdata_valid && o_sdata_accept;
      csr_fire   = o_csr_mcmd_valid && i_csr_scmd_accept;
      resp_fire  = i_csr_sresp_valid && o_csr_mresp_accept;
      mresp_fire = o_sresp_valid && i_mresp_accept;
      if (csr_fire) begin
        assert (exp_csr.size() > 0)
          else fail_plain("CSR command issued when none was expected");
        c = exp_csr.pop_front();
        check_value("csr cmd", 64'(c.cmd), 64'(o_csr_mcmd));
        check_value("csr addr", 64'(c.addr), 64'(o_csr_maddr));
        if (c.cmd != m2c_pkg::CMD_READ) begin
          check_value("csr data", 64'(c.data), 64'(o_csr_mdata));
          check_value("csr byteen", 64'(c.be), 64'(o_csr_mdata_byteen));
          for (int j = 0; j < 4; j++) begin
            if (o_csr_mdata_byteen[j]) begin
              regs[o_csr_maddr[5:2]][8*j+:8] = o_csr_mdata[8*j+:8];
            end
          end
        end
        if (o_csr_mcmd == m2c_pkg::CMD_READ) begin
          pend.push_back({(int'(o_csr_maddr[5:2]) == ERR_REG), regs[o_csr_maddr[5:2]]});
        end else if (o_csr_mcmd == m2c_pkg::CMD_WRITE_NP) begin
          pend.push_back({(int'(o_csr_maddr[5:2]) == ERR_REG), 32'h0});
        end
      end
      if (mresp_fire) begin
        assert (exp_resp.size() > 0)
          else fail_plain("memory-bus response arrived unexpectedly");
        m = exp_resp.pop_front();
        check_value("sresp", 64'(m.kind), 64'(o_sresp));
        check_value("sid", 64'(m.id), 64'(o_sid));
        check_value("sdata", m.data, o_sdata & m.mask);
        check_value("serror", 64'(m.err), 64'(o_serror));
        check_value("sresp_last", 64'(m.last), 64'(o_sresp_last));
      end
      @(posedge i_clk);
      #1;
      if (cmd_fire) begin
        i_mcmd_valid  = 1'b0;
        i_mdata_valid = 1'b0;
        req_done      = 1'b1;
      end else if (data_fire) begin
        beat_idx++;
        i_mdata        = cur_data[beat_idx];
        i_mdata_byteen = cur_be[beat_idx];
      end
      if (resp_fire) begin
        void'(pend.pop_front());
        i_csr_sresp_valid = 1'b0;
        i_csr_serror      = 1'b0;
      end
      if (!i_csr_sresp_valid && pend.size() > 0 && take_bit()) begin
        i_csr_sresp_valid           = 1'b1;
        {i_csr_serror, i_csr_sdata} = pend[0];
      end
      i_csr_scmd_accept = take_bit();
      i_csr_scmd_accept = i_csr_scmd_accept | take_bit();
      i_mresp_accept    = take_bit();
      i_mresp_accept    = i_mresp_accept | take_bit();
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  initial begin
    cycles = 0;
    cur_name = "reset";
    i_rst_n = 1'b0;
    i_force_np_write = 1'b0;
    i_mcmd_valid = 1'b0;
    i_mcmd = m2c_pkg::CMD_READ;
    i_mid = 4'h0;
    i_maddr = 16'h0;
    i_mlength = 4'd1;
    i_mdata_valid = 1'b0;
    i_mdata = 64'h0;
    i_mdata_byteen = 8'h0;
    i_mresp_accept = 1'b0;
    i_csr_scmd_accept = 1'b0;
    i_csr_sresp_valid = 1'b0;
    i_csr_sdata = 32'h0;
    i_csr_serror = 1'b0;
    req_done = 1'b0;
    beat_idx = 0;
    for (int i = 0; i < 16; i++) begin
      regs[i] = 32'hc0de_0000 | (32'(i) * 32'h0000_0101);
      shadow[i] = regs[i];
    end
    fill_rows();
    repeat (2) @(posedge i_clk);
    #1 i_rst_n = 1'b1;
    @(negedge i_clk);
    check_value("scmd_accept", 64'h0, 64'(o_scmd_accept));
    check_value("sresp_valid", 64'h0, 64'(o_sresp_valid));
    check_value("csr_mcmd_valid", 64'h0, 64'(o_csr_mcmd_valid));
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge i_clk);
      #1;
      cur_name = rows[r].name;
      plan_row(rows[r]);
      cur_data = rows[r].data;
      cur_be = rows[r].be;
      beat_idx = 0;
      req_done = 1'b0;
      i_force_np_write = rows[r].force_np;
      i_mcmd = rows[r].cmd;
      i_mid = rows[r].id;
      i_maddr = rows[r].addr;
      i_mlength = rows[r].len;
      i_mdata = rows[r].data[0];
      i_mdata_byteen = rows[r].be[0];
      i_mdata_valid = (rows[r].cmd != m2c_pkg::CMD_READ);
      i_mcmd_valid = 1'b1;
      while (!(req_done && exp_csr.size() == 0 && exp_resp.size() == 0 &&
               pend.size() == 0 && !i_csr_sresp_valid)) begin
        @(negedge i_clk);
      end
      for (int i = 0; i < 16; i++) begin
        check_value($sformatf("reg %0d", i), 64'(shadow[i]), 64'(regs[i]));
      end
    end
    repeat (4) @(negedge i_clk);
    check_value("idle sresp_valid", 64'h0, 64'(o_sresp_valid));
    $display("Result: PASSED");
    $finish;
  end
endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/m2c_pkg.sv
logic/m2c_track_if.sv
logic/m2c_fifo.sv
logic/m2c_response_tracker.sv
logic/m2c_request_splitter.sv
logic/m2c_response_merger.sv
logic/membus2csrbus_adapter.sv
tb/tb_membus2csrbus_adapter.sv

/* run.sh */
#!/bin/sh
# Compile and run the adapter testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_membus2csrbus_adapter -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
